// ==== design/xbus_pkg.sv ====
// bus unit shared constants
// address map, data memory geometry and wishbone timing for the whole subsystem
package xbus_pkg;

    // ----------------------------------------------------------
    // address map
    // ----------------------------------------------------------
    localparam logic [31:0] dmem_base     = 32'h8000_0000; // internal data memory window
    localparam logic [31:0] reserved_base = 32'hffff_0000; // no device behind it here

    // ----------------------------------------------------------
    // data memory geometry
    // ----------------------------------------------------------
    localparam int dmem_size  = 4096;             // bytes
    localparam int dmem_abits = $clog2(dmem_size); // byte offset bits inside the window
    localparam int dmem_depth = dmem_size / 4;    // 32-bit words

    // ----------------------------------------------------------
    // wishbone gateway
    // ----------------------------------------------------------
    // cycles an access may wait for ack or err before it is dropped
    localparam int bus_timeout = 16;

    // down-counter sizing
    localparam int tmo_cnt_w = $clog2(bus_timeout + 1);
    localparam logic [tmo_cnt_w-1:0] tmo_init = bus_timeout[tmo_cnt_w-1:0]; // reload value

    // request tag layout, 2 bits
    localparam int tag_priv_bit = 0; // 1 = privileged access
    localparam int tag_src_bit  = 1; // 1 = instruction fetch

endpackage

// ==== design/xbus_decoder.sv ====
// address decoder for the host port
// routes a request to data memory or gateway, errors the reserved window
// and merges the target responses
module xbus_decoder (
    input  logic        clk_i,       // bus clock
    input  logic        rstn_i,      // async active-low reset
    // host request
    input  logic [31:0] addr_i,      // request address
    input  logic        rden_i,      // one-cycle read strobe
    input  logic        wren_i,      // one-cycle write strobe
    // target strobes
    output logic        mem_req_o,   // data memory request
    output logic        mem_we_o,    // data memory write
    output logic        gw_req_o,    // gateway request
    output logic        gw_we_o,     // gateway write
    // target responses
    input  logic        mem_ack_i,   // data memory ack
    input  logic [31:0] mem_rdata_i, // zero when not acking
    input  logic        gw_ack_i,    // gateway ack
    input  logic        gw_err_i,    // gateway bus error
    input  logic        gw_tmo_i,    // gateway timeout
    input  logic [31:0] gw_rdata_i,  // zero when not acking
    // merged host response
    output logic        ack_o,       // transfer done
    output logic        err_o,       // transfer error
    output logic        tmo_o,       // transfer timeout
    output logic [31:0] data_o       // read data that is zero unless ack_o
);

    logic host_req; // any strobe this cycle
    logic mem_hit;  // address in data memory window
    logic rsv_hit;  // address in reserved window
    logic ext_hit;  // everything else goes external
    logic rsv_err;  // delayed error for reserved window

    // ----------------------------------------------------------
    // window compare
    // ----------------------------------------------------------
    assign host_req = rden_i | wren_i;
    assign mem_hit  = (addr_i[31:xbus_pkg::dmem_abits] ==
                       xbus_pkg::dmem_base[31:xbus_pkg::dmem_abits]);
    assign rsv_hit  = (addr_i[31:16] == xbus_pkg::reserved_base[31:16]); // upper 64k
    assign ext_hit  = ~mem_hit & ~rsv_hit;

    // exactly one strobe, or none for the reserved window
    assign mem_req_o = host_req & mem_hit;
    assign mem_we_o  = wren_i & mem_hit;
    assign gw_req_o  = host_req & ext_hit;
    assign gw_we_o   = wren_i & ext_hit;

    // reserved access answers one cycle later like a real device would
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rsv_err <= 1'b0;
        end else begin
            rsv_err <= host_req & rsv_hit; // single pulse
        end
    end

    // ----------------------------------------------------------
    // response merge
    // ----------------------------------------------------------
    // targets keep idle outputs at zero so a plain OR is enough
    assign ack_o  = mem_ack_i | gw_ack_i;
    assign err_o  = rsv_err | gw_err_i;
    assign tmo_o  = gw_tmo_i;                  // only the gateway can time out
    assign data_o = mem_rdata_i | gw_rdata_i;

endmodule

// ==== design/xbus_dmem.sv ====
// internal data memory
// word array with byte write enables, registered ack and read data
module xbus_dmem (
    input  logic        clk_i,   // bus clock
    input  logic        rstn_i,  // async reset, low active
    input  logic        req_i,   // access strobe, one cycle
    input  logic        we_i,    // 1 = write
    input  logic [31:0] addr_i,  // byte address
    input  logic [3:0]  ben_i,   // byte write enables
    input  logic [31:0] wdata_i, // write data
    output logic        ack_o,   // one cycle after req_i
    output logic [31:0] rdata_o  // zero unless ack_o
);

    logic [31:0] mem [xbus_pkg::dmem_depth]; // storage, no reset
    logic [xbus_pkg::dmem_abits-3:0] word_idx; // word index in window

    assign word_idx = addr_i[xbus_pkg::dmem_abits-1:2]; // drop byte offset

    // ----------------------------------------------------------
    // write port
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (ben_i[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8]; // enabled lanes only
                end
            end
        end
    end

    // ----------------------------------------------------------
    // response
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_o   <= 1'b0;
            rdata_o <= '0;
        end else begin
            ack_o <= req_i; // fixed single cycle latency
            if (req_i && !we_i) begin
                rdata_o <= mem[word_idx]; // old contents
            end else begin
                rdata_o <= '0; // keeps the OR merge clean
            end
        end
    end

endmodule

// ==== design/xbus_gateway.sv ====
// registered wishbone classic gateway
// one access at a time, ends on ack, err or timeout
module xbus_gateway (
    input  logic        clk_i,    // bus clock
    input  logic        rstn_i,   // async reset, low active
    // host side
    input  logic        req_i,    // external request, one cycle
    input  logic        we_i,     // 1 = write
    input  logic        src_i,    // 0 = data, 1 = instruction
    input  logic        priv_i,   // 1 = privileged
    input  logic [31:0] addr_i,   // byte address
    input  logic [3:0]  ben_i,    // byte enables
    input  logic [31:0] wdata_i,  // write data
    output logic        ack_o,    // access done
    output logic        err_o,    // slave error
    output logic        tmo_o,    // no answer in time
    output logic [31:0] rdata_o,  // zero unless ack_o
    output logic        busy_o,   // access in flight
    // wishbone master
    output logic        wb_cyc_o, // cycle valid
    output logic        wb_stb_o, // strobe, same as cyc in classic mode
    output logic        wb_we_o,  // write enable
    output logic [31:0] wb_adr_o, // address
    output logic [31:0] wb_dat_o, // write data
    output logic [3:0]  wb_sel_o, // byte select
    output logic [1:0]  wb_tag_o, // priv and source
    input  logic [31:0] wb_dat_i, // read data
    input  logic        wb_ack_i, // slave ack
    input  logic        wb_err_i  // slave error
);

    typedef enum logic {
        idle_s,
        busy_s
    } state_t;

    state_t state;

    // outgoing request registers, held while idle
    logic        we_q;
    logic [31:0] adr_q;
    logic [31:0] wdat_q;
    logic [3:0]  sel_q;
    logic [1:0]  tag_q;

    // registered response
    logic        ack_q;
    logic        err_q;
    logic        tmo_q;
    logic [31:0] rdat_q;

    logic [xbus_pkg::tmo_cnt_w-1:0] tmo_cnt; // cycles left before timeout
    logic                           tmo_hit; // counter ran out

    assign tmo_hit = (tmo_cnt == '0);

    // ----------------------------------------------------------
    // access FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state   <= idle_s;
            we_q    <= 1'b0;
            adr_q   <= '0;
            wdat_q  <= '0;
            sel_q   <= '0;
            tag_q   <= '0;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            tmo_q   <= 1'b0;
            rdat_q  <= '0;
            tmo_cnt <= xbus_pkg::tmo_init;
        end else begin
            // response pulses last one cycle
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            tmo_q  <= 1'b0;
            rdat_q <= '0;
            case (state)
                idle_s: begin
                    tmo_cnt <= xbus_pkg::tmo_init; // rearm for next access
                    if (req_i) begin
                        we_q   <= we_i;
                        adr_q  <= addr_i;
                        wdat_q <= wdata_i;
                        sel_q  <= ben_i;
                        tag_q[xbus_pkg::tag_priv_bit] <= priv_i;
                        tag_q[xbus_pkg::tag_src_bit]  <= src_i;
                        state  <= busy_s; // cyc rises next cycle
                    end
                end
                busy_s: begin
                    tmo_cnt <= tmo_cnt - {{(xbus_pkg::tmo_cnt_w-1){1'b0}}, 1'b1};
                    if (wb_err_i) begin                  // error wins
                        err_q <= 1'b1;
                        state <= idle_s;
                    end else if (tmo_hit) begin          // slave stayed silent
                        tmo_q <= 1'b1;
                        state <= idle_s;
                    end else if (wb_ack_i) begin         // normal end
                        ack_q  <= 1'b1;
                        rdat_q <= we_q ? '0 : wb_dat_i;  // capture reads only
                        state  <= idle_s;
                    end
                end
                default: state <= idle_s;
            endcase
        end
    end

    // ----------------------------------------------------------
    // outputs
    // ----------------------------------------------------------
    assign busy_o   = (state == busy_s);
    assign wb_cyc_o = (state == busy_s);
    assign wb_stb_o = (state == busy_s); // classic mode
    assign wb_we_o  = we_q;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = wdat_q;
    assign wb_sel_o = sel_q;
    assign wb_tag_o = tag_q;

    assign ack_o   = ack_q;
    assign err_o   = err_q;
    assign tmo_o   = tmo_q;
    assign rdata_o = rdat_q; // cleared in every cycle without ack

endmodule

// ==== design/xbus_top.sv ====
// host bus unit top
// decoder, internal data memory and external wishbone gateway
module xbus_top (
    input  logic        clk_i,    // bus clock
    input  logic        rstn_i,   // async reset, low active
    // host port
    input  logic        src_i,    // 0 = data, 1 = instruction
    input  logic        priv_i,   // 1 = privileged
    input  logic [31:0] addr_i,   // byte address
    input  logic        rden_i,   // read strobe
    input  logic        wren_i,   // write strobe
    input  logic [3:0]  ben_i,    // byte enables
    input  logic [31:0] data_i,   // write data
    output logic [31:0] data_o,   // read data, valid with ack_o
    output logic        ack_o,    // done
    output logic        err_o,    // error
    output logic        tmo_o,    // timeout
    output logic        busy_o,   // external access in flight
    // wishbone port
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output logic [31:0] wb_adr_o,
    output logic [31:0] wb_dat_o,
    output logic [3:0]  wb_sel_o,
    output logic [1:0]  wb_tag_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i,
    input  logic        wb_err_i
);

    // decoder to data memory
    logic        mem_req;
    logic        mem_we;
    logic        mem_ack;
    logic [31:0] mem_rdata;

    // decoder to gateway
    logic        gw_req;
    logic        gw_we;
    logic        gw_ack;
    logic        gw_err;
    logic        gw_tmo;
    logic [31:0] gw_rdata;

    xbus_decoder u_decoder (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .addr_i      (addr_i),
        .rden_i      (rden_i),
        .wren_i      (wren_i),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .gw_req_o    (gw_req),
        .gw_we_o     (gw_we),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata),
        .gw_ack_i    (gw_ack),
        .gw_err_i    (gw_err),
        .gw_tmo_i    (gw_tmo),
        .gw_rdata_i  (gw_rdata),
        .ack_o       (ack_o),
        .err_o       (err_o),
        .tmo_o       (tmo_o),
        .data_o      (data_o)
    );

    xbus_dmem u_dmem (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .req_i   (mem_req),
        .we_i    (mem_we),
        .addr_i  (addr_i),
        .ben_i   (ben_i),
        .wdata_i (data_i),
        .ack_o   (mem_ack),
        .rdata_o (mem_rdata)
    );

    xbus_gateway u_gateway (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .req_i    (gw_req),
        .we_i     (gw_we),
        .src_i    (src_i),
        .priv_i   (priv_i),
        .addr_i   (addr_i),
        .ben_i    (ben_i),
        .wdata_i  (data_i),
        .ack_o    (gw_ack),
        .err_o    (gw_err),
        .tmo_o    (gw_tmo),
        .rdata_o  (gw_rdata),
        .busy_o   (busy_o),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_tag_o (wb_tag_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .wb_err_i (wb_err_i)
    );

endmodule

// ==== dv/wb_slave_model.sv ====
// behavioral wishbone classic slave for the testbench
// word memory with selectable wait states, an error window and a silent window
module wb_slave_model #(
    parameter logic [31:0] err_base = 32'h4000_0000, // answers with err
    parameter logic [31:0] sil_base = 32'h5000_0000  // never answers
) (
    input  logic        clk_i,   // bus clock
    input  logic        rstn_i,  // async reset, low active
    input  logic [2:0]  wait_i,  // wait states before the answer
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    input  logic [3:0]  sel_i,
    output logic [31:0] dat_o,   // registered read data
    output logic        ack_o,   // registered ack
    output logic        err_o    // registered error
);

    logic [31:0] mem [256]; // external memory, word index adr[9:2]
    logic [2:0]  wait_cnt;  // wait states spent so far
    logic [7:0]  idx;

    assign idx = adr_i[9:2];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_o    <= 1'b0;
            err_o    <= 1'b0;
            dat_o    <= '0;
            wait_cnt <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {~i[7:0], i[7:0], i[7:0] ^ 8'h3c, i[7:0] + 8'h5a}; // per word fill
            end
        end else begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
            dat_o <= '0;
            if (!cyc_i || !stb_i || ack_o || err_o) begin
                wait_cnt <= '0; // idle, or answer already given
            end else if (wait_cnt != wait_i) begin
                wait_cnt <= wait_cnt + 3'd1;
            end else if (adr_i[31:28] == err_base[31:28]) begin
                err_o <= 1'b1; // no write on error
            end else if (adr_i[31:28] != sil_base[31:28]) begin
                ack_o <= 1'b1;
                if (we_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel_i[b]) begin
                            mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end
                end else begin
                    dat_o <= mem[idx];
                end
            end
        end
    end

endmodule

// ==== dv/tb_xbus.sv ====
// testbench for the host bus unit
// random traffic to data memory, external bus, error, reserved and silent windows
module tb_xbus;

    localparam logic [31:0] ext_base  = 32'h1000_0000; // plain external memory
    localparam logic [31:0] err_base  = 32'h4000_0000; // slave answers with err
    localparam logic [31:0] sil_base  = 32'h5000_0000; // slave stays silent
    localparam logic [31:0] lfsr_seed = 32'd32;
    localparam int          resp_wait = 64;            // cycles before a wait gives up

    logic        clk;
    logic        rstn;
    logic        src;
    logic        priv;
    logic [31:0] addr;
    logic        rden;
    logic        wren;
    logic [3:0]  ben;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        ack;
    logic        err;
    logic        tmo;
    logic        busy;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_m; // master to slave
    logic [3:0]  wb_sel;
    logic [1:0]  wb_tag;
    logic [31:0] wb_dat_s; // slave to master
    logic        wb_ack;
    logic        wb_err;
    logic [2:0]  wait_sel; // slave wait states

    logic [31:0] lfsr_q;
    logic [31:0] dmem_ref [xbus_pkg::dmem_depth]; // reference copies
    logic [31:0] ext_ref [256];
    logic [31:0] exp_adr;  // request as seen on the host side
    logic [31:0] exp_dat;
    logic [3:0]  exp_sel;
    logic        exp_we;
    logic [1:0]  exp_tag;
    int          resp;     // 1 ack, 2 err, 3 tmo
    int          lat;      // cycles from request to response
    logic [31:0] rd;
    int          cyc_run;
    int          cyc_len;  // last finished wishbone cycle
    int          cyc_total;

    always #4 clk = ~clk;

    xbus_top dut (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .src_i    (src),
        .priv_i   (priv),
        .addr_i   (addr),
        .rden_i   (rden),
        .wren_i   (wren),
        .ben_i    (ben),
        .data_i   (wdata),
        .data_o   (rdata),
        .ack_o    (ack),
        .err_o    (err),
        .tmo_o    (tmo),
        .busy_o   (busy),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat_m),
        .wb_sel_o (wb_sel),
        .wb_tag_o (wb_tag),
        .wb_dat_i (wb_dat_s),
        .wb_ack_i (wb_ack),
        .wb_err_i (wb_err)
    );

    wb_slave_model #(
        .err_base (err_base),
        .sil_base (sil_base)
    ) u_slave (
        .clk_i  (clk),
        .rstn_i (rstn),
        .wait_i (wait_sel),
        .cyc_i  (wb_cyc),
        .stb_i  (wb_stb),
        .we_i   (wb_we),
        .adr_i  (wb_adr),
        .dat_i  (wb_dat_m),
        .sel_i  (wb_sel),
        .dat_o  (wb_dat_s),
        .ack_o  (wb_ack),
        .err_o  (wb_err)
    );

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q); // one step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic fail_text(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        fail_text($sformatf("[ERROR] time %0t: %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else fail_value(name, exp, act);
    endtask

    // ----------------------------------------------------------
    // protocol checks
    // ----------------------------------------------------------
    assert property (@(posedge clk) disable iff (!rstn) !ack |-> rdata == '0)
        else fail_value("data_o", '0, $sampled(rdata));

    assert property (@(posedge clk) disable iff (!rstn)
        wb_cyc && $past(wb_cyc) |-> $stable({wb_we, wb_adr, wb_dat_m, wb_sel, wb_tag}))
        else fail_text("wishbone request changed inside an active cycle");

    // sampled mid-cycle since inputs move just after the rising edge
    always @(negedge clk) begin
        if (rstn) begin
            check_eq("wb_stb_o", 32'(wb_cyc), 32'(wb_stb));
            check_eq("busy_o", 32'(wb_cyc), 32'(busy));
            assert ($onehot0({ack, err, tmo})) else fail_text("more than one response at once");
            if (wb_cyc) begin
                check_eq("wb_adr_o", exp_adr, wb_adr);
                check_eq("wb_we_o", 32'(exp_we), 32'(wb_we));
                check_eq("wb_sel_o", 32'(exp_sel), 32'(wb_sel));
                check_eq("wb_dat_o", exp_dat, wb_dat_m);
                check_eq("wb_tag_o", 32'(exp_tag), 32'(wb_tag));
                cyc_run++;
                cyc_total++;
            end else if (cyc_run != 0) begin
                cyc_len = cyc_run; // cycle just ended
                cyc_run = 0;
            end
        end
    end

    // ----------------------------------------------------------
    // host accesses
    // ----------------------------------------------------------
    task automatic access(input logic we, input logic [31:0] adr, input logic [3:0] be,
                          input logic [31:0] wd);
        @(posedge clk);
        #1;
        src     = 1'(rand_bits(1));
        priv    = 1'(rand_bits(1));
        addr    = adr;
        ben     = be;
        wdata   = wd;
        rden    = ~we;
        wren    = we;
        exp_adr = adr;
        exp_dat = wd;
        exp_sel = be;
        exp_we  = we;
        exp_tag[xbus_pkg::tag_priv_bit] = priv;
        exp_tag[xbus_pkg::tag_src_bit]  = src;
        @(posedge clk);
        #1;
        rden = 1'b0; // one cycle strobe
        wren = 1'b0;
        resp = 0;
        lat  = 0;
        while (resp == 0) begin
            @(negedge clk);
            lat++;
            if (ack) begin
                resp = 1;
            end else if (err) begin
                resp = 2;
            end else if (tmo) begin
                resp = 3;
            end else if (lat >= resp_wait) begin
                fail_text("no response from the bus unit within 64 cycles");
            end
        end
        rd = rdata;
        @(negedge clk);
        assert (!(ack || err || tmo)) else fail_text("response pulse lasted more than one cycle");
    endtask

    task automatic dmem_access(input logic we, input int idx, input logic [3:0] be);
        logic [31:0] wd;
        int          cyc_before;
        wd         = rand_bits(32);
        cyc_before = cyc_total;
        access(we, xbus_pkg::dmem_base + 32'(idx * 4), be, wd);
        check_eq("ack_o", 1, resp);
        check_eq("ack_o latency", 1, lat);
        check_eq("wb_cyc_o cycles", cyc_before, cyc_total); // memory stays internal
        if (we) begin
            dmem_ref[idx] = merge_bytes(dmem_ref[idx], wd, be);
        end else begin
            check_eq("data_o", dmem_ref[idx], rd);
        end
    endtask

    task automatic ext_access(input logic we, input int idx, input logic [3:0] be);
        logic [31:0] wd;
        wd       = rand_bits(32);
        wait_sel = 3'(rand_bits(3)); // 0 to 7 wait states
        access(we, ext_base + 32'(idx * 4), be, wd);
        check_eq("ack_o", 1, resp);
        // registered slave answers wait_sel+1 cycles after cyc rises
        check_eq("wb_cyc_o cycles", 32'(wait_sel) + 2, cyc_len);
        check_eq("ack_o latency", 32'(wait_sel) + 3, lat);
        if (we) begin
            ext_ref[idx] = merge_bytes(ext_ref[idx], wd, be);
        end else begin
            check_eq("data_o", ext_ref[idx], rd);
        end
    endtask

    task automatic err_access(input logic we, input int idx);
        access(we, err_base + 32'(idx * 4), 4'hf, rand_bits(32));
        check_eq("err_o", 2, resp);
        check_eq("wb_cyc_o cycles", 32'(wait_sel) + 2, cyc_len);
        check_eq("err_o latency", 32'(wait_sel) + 3, lat);
        ext_access(1'b0, idx, 4'hf); // word must be untouched
    endtask

    task automatic rsv_access(input logic we);
        int cyc_before;
        cyc_before = cyc_total;
        access(we, xbus_pkg::reserved_base + 32'(rand_bits(16)), 4'hf, rand_bits(32));
        check_eq("err_o", 2, resp);
        check_eq("err_o latency", 1, lat);
        check_eq("wb_cyc_o cycles", cyc_before, cyc_total);
    endtask

    task automatic silent_access(input logic we);
        access(we, sil_base + 32'(rand_bits(10) << 2), 4'hf, rand_bits(32));
        check_eq("tmo_o", 3, resp);
        check_eq("wb_cyc_o cycles", xbus_pkg::bus_timeout + 1, cyc_len);
        check_eq("tmo_o latency", xbus_pkg::bus_timeout + 2, lat);
        ext_access(1'b0, int'(rand_bits(8)), 4'hf); // bus still usable
    endtask

    task automatic check_idle;
        check_eq("wb_cyc_o", 0, 32'(wb_cyc));
        check_eq("wb_stb_o", 0, 32'(wb_stb));
        check_eq("wb_we_o", 0, 32'(wb_we));
        check_eq("ack_o", 0, 32'(ack));
        check_eq("err_o", 0, 32'(err));
        check_eq("tmo_o", 0, 32'(tmo));
        check_eq("busy_o", 0, 32'(busy));
        check_eq("data_o", 0, rdata);
        check_eq("wb_adr_o", 0, wb_adr);
        check_eq("wb_dat_o", 0, wb_dat_m);
        check_eq("wb_sel_o", 0, 32'(wb_sel));
        check_eq("wb_tag_o", 0, 32'(wb_tag));
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        int idx;
        clk       = 1'b0;
        rstn      = 1'b0;
        src       = 1'b0;
        priv      = 1'b0;
        addr      = '0;
        rden      = 1'b0;
        wren      = 1'b0;
        ben       = '0;
        wdata     = '0;
        wait_sel  = '0;
        lfsr_q    = lfsr_seed;
        exp_adr   = '0;
        exp_dat   = '0;
        exp_sel   = '0;
        exp_we    = 1'b0;
        exp_tag   = '0;
        cyc_run   = 0;
        cyc_len   = 0;
        cyc_total = 0;
        for (int i = 0; i < 256; i++) begin
            ext_ref[i] = {~i[7:0], i[7:0], i[7:0] ^ 8'h3c, i[7:0] + 8'h5a}; // slave fill
        end

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_idle(); // still in reset
        @(posedge clk);
        #1;
        rstn = 1'b1; // 16 cycles of reset
        @(negedge clk);
        check_idle();

        // internal memory gets a full word first so every byte is known
        for (int n = 0; n < 24; n++) begin
            idx = int'(rand_bits(xbus_pkg::dmem_abits - 2));
            dmem_access(1'b1, idx, 4'hf);
            dmem_access(1'b1, idx, 4'(rand_bits(4)));
            dmem_access(1'b0, idx, 4'hf);
        end

        // external memory at random latency
        for (int n = 0; n < 24; n++) begin
            idx = int'(rand_bits(8));
            ext_access(1'b1, idx, 4'(rand_bits(4)));
            ext_access(1'b0, idx, 4'hf);
        end

        // error and reserved windows
        for (int n = 0; n < 4; n++) begin
            err_access(1'(rand_bits(1)), int'(rand_bits(8)));
            rsv_access(1'(rand_bits(1)));
        end

        silent_access(1'b0);
        silent_access(1'b1);

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== src.f ====
design/xbus_pkg.sv
design/xbus_decoder.sv
design/xbus_dmem.sv
design/xbus_gateway.sv
design/xbus_top.sv
dv/wb_slave_model.sv
dv/tb_xbus.sv

// ==== run.sh ====
#!/bin/sh
# Build the bus unit testbench with Verilator and run it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_xbus \
    -Mdir obj_dir \
    -o tb_xbus
status=$?
if [ "$status" -ne 0 ]; then
    echo "run.sh: verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_xbus
status=$?
if [ "$status" -ne 0 ]; then
    echo "run.sh: simulation failed with status $status"
    exit "$status"
fi

exit 0
